//--- Makefile
TOP = tb_fw_ip2

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f project.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

//--- hw/bxclk_gen.sv
/* bxclk_ana and bxclk generator counted in fw_axi_clk cycles
   Period below 2 stops both clocks; delay must not exceed half the period */
module bxclk_gen import fw_ip2_pkg::*; (
  input  logic               fw_axi_clk,
  input  logic               op_code_w_reset,
  input  logic [23:0]        static_word,
  output logic [PHASE_W-1:0] phase,
  output logic               bxclk_ana,
  output logic               bxclk
);

  logic [PHASE_W-1:0]                         period;
  logic [PHASE_W-1:0]                         half;      // High time, rounded down
  logic [BXCLK_DELAY_MSB-BXCLK_DELAY_LSB:0]   delay;
  logic                                       delay_sign;
  logic                                       run;
  logic [PHASE_W-1:0]                         ph_late;   // Phase seen delay cycles ago
  logic [PHASE_W:0]                           ph_sum;
  logic [PHASE_W-1:0]                         ph_early;  // Phase delay cycles ahead
  logic [PHASE_W-1:0]                         ph_bx;

  assign period     = static_word[BXCLK_PERIOD_MSB:BXCLK_PERIOD_LSB];
  assign delay      = static_word[BXCLK_DELAY_MSB:BXCLK_DELAY_LSB];
  assign delay_sign = static_word[BXCLK_DELAY_SIGN];
  assign run        = (period > PHASE_W'(1));
  assign half       = period >> 1;

  // Shifted phase, one wrap at most since delay is within half a period
  assign ph_late  = (phase >= PHASE_W'(delay)) ? phase - PHASE_W'(delay)
                                               : phase + period - PHASE_W'(delay);
  assign ph_sum   = {1'b0, phase} + (PHASE_W+1)'(delay);
  assign ph_early = (ph_sum >= {1'b0, period}) ? PHASE_W'(ph_sum - {1'b0, period})
                                               : PHASE_W'(ph_sum);
  assign ph_bx    = delay_sign ? ph_early : ph_late;

  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset || !run) begin
      phase     <= '0;
      bxclk_ana <= 1'b0;
      bxclk     <= 1'b0;
    end else begin
      phase     <= (phase >= period - 1'b1) ? '0 : phase + 1'b1;  // Also catches a shrunk period
      bxclk_ana <= (phase < half);
      bxclk     <= (ph_bx < half);                         // Same waveform, shifted
    end
  end

endmodule

//--- hw/cfg_store.sv
/* Static word, configuration array and the registered software read mux
   Array reads wrap at the last word; data reads past the capture return zero */
module cfg_store import fw_ip2_pkg::*; (
  input  logic                 fw_axi_clk,
  input  logic                 op_code_w_reset,
  input  logic                 wr_static,
  input  logic                 wr_array,
  input  rd_sel_t              rd_sel,
  input  logic [23:0]          sw_write24,
  input  logic [SCAN_BITS-1:0] capture_data,
  output logic [23:0]          static_word,
  output logic [SCAN_BITS-1:0] cfg_array,
  output logic [31:0]          read_data32
);

  localparam int DATA_SEL_W = $clog2(DATA_WORDS);

  logic [CFG_WORDS-1:0][ARRAY_DATA_MSB:0] cfg_mem;          // Word 0 leaves the chain first
  logic [DATA_WORDS-1:0][31:0]            data_words;       // Capture seen as 32-bit words
  logic [ARRAY_ADDR_W-1:0]                addr;
  logic [ARRAY_ADDR_W-1:0]                addr_next;        // Wraps to word 0
  logic [31:0]                            rd_mux;

  assign addr       = sw_write24[ARRAY_ADDR_LSB +: ARRAY_ADDR_W];
  assign addr_next  = addr + 1'b1;
  assign cfg_array  = cfg_mem;
  assign data_words = capture_data;

  // ------------------------------------------------------------------------
  // Write side
  // ------------------------------------------------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      static_word <= '0;                                   // Period 0 keeps bxclk low
    end else if (wr_static) begin
      static_word <= sw_write24;
    end
  end

  always_ff @(posedge fw_axi_clk) begin
    if (wr_array) cfg_mem[addr] <= sw_write24[ARRAY_DATA_MSB:0];
  end

  // ------------------------------------------------------------------------
  // Read side
  // ------------------------------------------------------------------------
  always_comb begin
    case (rd_sel)
      RD_CFG_STATIC: rd_mux = {8'h00, static_word};        // Zero pad to 32 bits
      RD_CFG_ARRAY:  rd_mux = {cfg_mem[addr_next], cfg_mem[addr]};
      RD_DATA_ARRAY: begin
        if (addr < ARRAY_ADDR_W'(DATA_WORDS)) rd_mux = data_words[addr[DATA_SEL_W-1:0]];
        else                                  rd_mux = '0;  // Out of range
      end
      default:       rd_mux = '0;
    endcase
  end

  // Loaded on a read strobe only, held until the next one
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      read_data32 <= '0;
    end else if (rd_sel != RD_NONE) begin
      read_data32 <= rd_mux;
    end
  end

endmodule

//--- hw/fw_ip2_ctrl.sv
/* Opcode decode, sticky status and the test1 sequencer
   Software must space strobes by two cycles or more, there is no back-pressure */
module fw_ip2_ctrl import fw_ip2_pkg::*; (
  input  logic               fw_axi_clk,
  input  logic               op_code_w_reset,
  input  logic               dev_id_enable,
  input  logic               op_strobe,
  input  op_code_t           op_code,
  input  logic [23:0]        sw_write24,
  input  logic [23:0]        static_word,
  input  logic [PHASE_W-1:0] phase,
  output logic               wr_static,
  output logic               wr_array,
  output rd_sel_t            rd_sel,
  output logic [31:0]        read_status32,
  output logic               reset_not,
  output logic               super_pixel_sel,
  output logic               scan_in,
  scan_if.ctrl               scan
);

  logic               op_valid;                            // Strobe for this device
  logic               do_execute;
  logic               do_clear;
  logic               cfg_err;                             // Bad execute settings
  logic [PHASE_W-1:0] bxclk_period;
  logic [PHASE_W-1:0] test_delay;                          // Latched execute fields
  logic [PHASE_W-1:0] test_sample;
  logic               test_loopback;
  logic               test_mask_reset_not;
  test_state_t        state;

  // ------------------------------------------------------------------------
  // Opcode decode
  // ------------------------------------------------------------------------
  assign op_valid   = op_strobe & dev_id_enable;
  assign wr_static  = op_valid && (op_code == OP_W_CFG_STATIC);
  assign wr_array   = op_valid && (op_code == OP_W_CFG_ARRAY);
  assign do_execute = op_valid && (op_code == OP_W_EXECUTE);
  assign do_clear   = op_valid && (op_code == OP_W_STATUS_CLEAR);

  always_comb begin
    rd_sel = RD_NONE;
    if (op_valid) begin
      case (op_code)
        OP_R_CFG_STATIC: rd_sel = RD_CFG_STATIC;
        OP_R_CFG_ARRAY:  rd_sel = RD_CFG_ARRAY;
        OP_R_DATA_ARRAY: rd_sel = RD_DATA_ARRAY;
        default:         rd_sel = RD_NONE;
      endcase
    end
  end

  // Delay must sit inside one bxclk period and leave room for LOAD
  assign bxclk_period = static_word[BXCLK_PERIOD_MSB:BXCLK_PERIOD_LSB];
  assign cfg_err = (sw_write24[TEST_DELAY_MSB:TEST_DELAY_LSB] < PHASE_W'(MIN_TEST_DELAY)) ||
                   (sw_write24[TEST_DELAY_MSB:TEST_DELAY_LSB] > bxclk_period);

  // Sticky status, only clear zeroes it
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset || do_clear) begin
      read_status32 <= '0;
    end else begin
      if (wr_static)                read_status32[ST_W_STATIC] <= 1'b1;
      if (rd_sel == RD_CFG_STATIC)  read_status32[ST_R_STATIC] <= 1'b1;
      if (wr_array)                 read_status32[ST_W_ARRAY]  <= 1'b1;
      if (rd_sel == RD_CFG_ARRAY)   read_status32[ST_R_ARRAY]  <= 1'b1;
      if (rd_sel == RD_DATA_ARRAY)  read_status32[ST_R_DATA]   <= 1'b1;
      if (do_execute) begin
        read_status32[ST_EXECUTE] <= 1'b1;
        read_status32[ST_DONE]    <= 1'b0;                 // New test pending
        if (cfg_err) read_status32[ST_CFG_ERR] <= 1'b1;
      end else if (state == DONE) begin
        read_status32[ST_DONE] <= 1'b1;
      end
    end
  end

  // Execute fields, held for the whole test
  always_ff @(posedge fw_axi_clk) begin
    if (do_execute) begin
      test_delay          <= sw_write24[TEST_DELAY_MSB:TEST_DELAY_LSB];
      test_sample         <= sw_write24[TEST_SAMPLE_MSB:TEST_SAMPLE_LSB];
      test_loopback       <= sw_write24[TEST_LOOPBACK];
      test_mask_reset_not <= sw_write24[TEST_MASK_RESET_NOT];
    end
  end

  // ------------------------------------------------------------------------
  // Test1 sequencer, paced by the bxclk phase
  // ------------------------------------------------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      state     <= IDLE;
      reset_not <= 1'b1;
    end else if (do_execute) begin
      state     <= DELAY_TEST;                             // Restarts a running test too
      reset_not <= 1'b1;
    end else begin
      case (state)
        DELAY_TEST: if (phase == test_delay) begin
          state     <= RESET_NOT;
          reset_not <= test_mask_reset_not;                // Low unless masked
        end
        RESET_NOT: if (phase == test_delay) begin          // One full period later
          state     <= LOAD;
          reset_not <= 1'b1;
        end
        LOAD:     state <= SHIFT_IN;
        SHIFT_IN: if (scan.shift_done) state <= DONE;      // SCAN_BITS periods
        IDLE, DONE: state <= state;                        // Wait for execute
        default:  state <= IDLE;
      endcase
    end
  end

  // Scan bus strobes
  assign scan.load     = (state == LOAD);
  assign scan.shift    = (state == SHIFT_IN) && (phase == test_delay) && !scan.shift_done;
  assign scan.sample   = (state == SHIFT_IN) &&
                         (test_loopback ? (phase == test_delay) : (phase == test_sample));
  assign scan.loopback = test_loopback;

  // ASIC side outputs
  assign scan_in         = (state == SHIFT_IN) && scan.bit0;
  assign super_pixel_sel = static_word[SUPER_PIX_SEL] && (state != IDLE);

endmodule

//--- hw/fw_ip2_pkg.sv
/* Shared types and field positions of the pixel ASIC scan-chain firmware
   Field layouts follow the software register map, so keep them in step with the driver */
package fw_ip2_pkg;

  // ------------------------------------------------------------------------
  // Software opcodes, states and read sources
  // ------------------------------------------------------------------------
  typedef enum logic [3:0] {
    OP_NONE           = 4'd0,
    OP_W_CFG_STATIC   = 4'd1,
    OP_R_CFG_STATIC   = 4'd2,
    OP_W_CFG_ARRAY    = 4'd3,
    OP_R_CFG_ARRAY    = 4'd4,
    OP_R_DATA_ARRAY   = 4'd5,
    OP_W_STATUS_CLEAR = 4'd6,
    OP_W_EXECUTE      = 4'd7
  } op_code_t;

  typedef enum logic [2:0] {
    IDLE, DELAY_TEST, RESET_NOT, LOAD, SHIFT_IN, DONE
  } test_state_t;

  typedef enum logic [1:0] {
    RD_NONE, RD_CFG_STATIC, RD_CFG_ARRAY, RD_DATA_ARRAY
  } rd_sel_t;

  // Sizes
  localparam int SCAN_BITS  = 64;                          // Scan-chain length
  localparam int CFG_WORDS  = 4;                           // 16-bit array words
  localparam int DATA_WORDS = 2;                           // 32-bit capture words
  localparam int PHASE_W    = 6;                           // Period and phase width

  // Static word fields
  localparam int BXCLK_PERIOD_LSB = 0;
  localparam int BXCLK_PERIOD_MSB = 5;
  localparam int BXCLK_DELAY_LSB  = 6;
  localparam int BXCLK_DELAY_MSB  = 10;
  localparam int BXCLK_DELAY_SIGN = 11;                    // 1 moves bxclk ahead of bxclk_ana
  localparam int SUPER_PIX_SEL    = 12;

  // Execute word fields
  localparam int TEST_DELAY_LSB      = 0;
  localparam int TEST_DELAY_MSB      = 5;
  localparam int TEST_SAMPLE_LSB     = 6;
  localparam int TEST_SAMPLE_MSB     = 11;
  localparam int TEST_LOOPBACK       = 16;
  localparam int TEST_MASK_RESET_NOT = 23;
  localparam int MIN_TEST_DELAY      = 3;                  // Smaller delays flag an error

  // Array access, address above the write data
  localparam int ARRAY_ADDR_LSB = 16;
  localparam int ARRAY_ADDR_W   = 2;
  localparam int ARRAY_DATA_MSB = 15;

  // Status bits, original layout
  localparam int ST_W_STATIC = 1;
  localparam int ST_R_STATIC = 2;
  localparam int ST_W_ARRAY  = 5;
  localparam int ST_R_ARRAY  = 6;
  localparam int ST_R_DATA   = 9;
  localparam int ST_EXECUTE  = 11;
  localparam int ST_DONE     = 12;
  localparam int ST_CFG_ERR  = 31;

endpackage

//--- hw/fw_ip2_top.sv
/* Firmware top for the pixel ASIC scan-chain test, single clock fw_axi_clk
   An opcode counts only on an op_strobe cycle with dev_id_enable high */
module fw_ip2_top import fw_ip2_pkg::*; (
  input  logic        fw_axi_clk,
  input  logic        op_code_w_reset,
  input  logic        dev_id_enable,
  input  logic        op_strobe,
  input  op_code_t    op_code,
  input  logic [23:0] sw_write24,
  input  logic        scan_out,                            // From the ASIC
  output logic [31:0] read_data32,
  output logic [31:0] read_status32,
  output logic        super_pixel_sel,
  output logic        reset_not,
  output logic        scan_in,
  output logic        bxclk,
  output logic        bxclk_ana
);

  logic                 wr_static;
  logic                 wr_array;
  rd_sel_t              rd_sel;
  logic [23:0]          static_word;
  logic [SCAN_BITS-1:0] cfg_array;                         // Image for the scan chain
  logic [SCAN_BITS-1:0] capture_data;
  logic [PHASE_W-1:0]   phase;

  scan_if scan_bus ();

  fw_ip2_ctrl fw_ip2_ctrl_inst (
    .fw_axi_clk      (fw_axi_clk),
    .op_code_w_reset (op_code_w_reset),
    .dev_id_enable   (dev_id_enable),
    .op_strobe       (op_strobe),
    .op_code         (op_code),
    .sw_write24      (sw_write24),
    .static_word     (static_word),
    .phase           (phase),
    .wr_static       (wr_static),
    .wr_array        (wr_array),
    .rd_sel          (rd_sel),
    .read_status32   (read_status32),
    .reset_not       (reset_not),
    .super_pixel_sel (super_pixel_sel),
    .scan_in         (scan_in),
    .scan            (scan_bus.ctrl)
  );

  cfg_store cfg_store_inst (
    .fw_axi_clk      (fw_axi_clk),
    .op_code_w_reset (op_code_w_reset),
    .wr_static       (wr_static),
    .wr_array        (wr_array),
    .rd_sel          (rd_sel),
    .sw_write24      (sw_write24),
    .capture_data    (capture_data),
    .static_word     (static_word),
    .cfg_array       (cfg_array),
    .read_data32     (read_data32)
  );

  bxclk_gen bxclk_gen_inst (
    .fw_axi_clk      (fw_axi_clk),
    .op_code_w_reset (op_code_w_reset),
    .static_word     (static_word),
    .phase           (phase),
    .bxclk_ana       (bxclk_ana),
    .bxclk           (bxclk)
  );

  scan_in_shifter scan_in_shifter_inst (
    .fw_axi_clk (fw_axi_clk),
    .cfg_array  (cfg_array),
    .scan       (scan_bus.shifter)
  );

  scan_out_capture scan_out_capture_inst (
    .fw_axi_clk   (fw_axi_clk),
    .scan_out     (scan_out),
    .capture_data (capture_data),
    .scan         (scan_bus.capture)
  );

endmodule

//--- hw/scan_if.sv
/* Scan bus between the test controller, the scan-in shifter and the capture
   All strobes are single-cycle and qualified by the controller state */
interface scan_if;

  logic load;                                              // Parallel load of the array image
  logic shift;                                             // Shift scan-in register right
  logic sample;                                            // Shift one bit into the capture
  logic loopback;                                          // Capture bit0 instead of scan_out
  logic bit0;                                              // Current scan-in bit
  logic shift_done;                                        // All SCAN_BITS shifted out

  modport ctrl (
    output load, shift, sample, loopback,
    input  bit0, shift_done
  );

  modport shifter (
    input  load, shift,
    output bit0, shift_done
  );

  modport capture (
    input sample, loopback, bit0
  );

endinterface

//--- hw/scan_in_shifter.sv
/* Scan-in register, loaded with the array image and shifted LSB first
   The shift count restarts on every load */
module scan_in_shifter import fw_ip2_pkg::*; (
  input  logic                 fw_axi_clk,
  input  logic [SCAN_BITS-1:0] cfg_array,
  scan_if.shifter              scan
);

  localparam int CNT_W = $clog2(SCAN_BITS) + 1;            // Holds SCAN_BITS itself

  logic [SCAN_BITS-1:0] shift_reg;
  logic [CNT_W-1:0]     shift_cnt;

  always_ff @(posedge fw_axi_clk) begin
    if (scan.load) begin
      shift_reg <= cfg_array;
      shift_cnt <= '0;
    end else if (scan.shift) begin
      shift_reg <= {1'b0, shift_reg[SCAN_BITS-1:1]};       // Next bit drops to bit0
      shift_cnt <= shift_cnt + 1'b1;
    end
  end

  assign scan.bit0       = shift_reg[0];
  assign scan.shift_done = (shift_cnt == CNT_W'(SCAN_BITS));

endmodule

//--- hw/scan_out_capture.sv
/* Capture of the returning scan data, first bit ends up in bit 0
   Contents are kept after a test until the next one overwrites them */
module scan_out_capture import fw_ip2_pkg::*; (
  input  logic                 fw_axi_clk,
  input  logic                 scan_out,
  output logic [SCAN_BITS-1:0] capture_data,
  scan_if.capture              scan
);

  logic sample_bit;

  // Loopback takes the bit driven on scan_in, sampled before it moves on
  assign sample_bit = scan.loopback ? scan.bit0 : scan_out;

  always_ff @(posedge fw_axi_clk) begin
    if (scan.sample) begin
      capture_data <= {sample_bit, capture_data[SCAN_BITS-1:1]};  // In at MSB
    end
  end

endmodule

//--- project.f
+incdir+verif
hw/fw_ip2_pkg.sv
hw/scan_if.sv
hw/fw_ip2_ctrl.sv
hw/cfg_store.sv
hw/bxclk_gen.sv
hw/scan_in_shifter.sv
hw/scan_out_capture.sv
hw/fw_ip2_top.sv
verif/tb_fw_ip2.sv

//--- verif/tb_fw_ip2_tasks.svh
/* Check task and directed tests, included inside tb_fw_ip2
   Every task is entered and left on a falling clock edge */

  // Compare one value, stop at the first mismatch
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  // One strobe cycle, then one idle cycle to keep strobes two cycles apart
  task automatic issue_op(input op_code_t code, input logic [23:0] data, input logic enable);
    op_code       = code;
    sw_write24    = data;
    dev_id_enable = enable;
    op_strobe     = 1'b1;
    @(negedge fw_axi_clk);
    op_strobe     = 1'b0;
    op_code       = OP_NONE;
    dev_id_enable = 1'b1;
    @(negedge fw_axi_clk);                                 // Result visible from here
  endtask

  task automatic read_op(input op_code_t code, input int addr);
    issue_op(code, {6'd0, 2'(addr), 16'd0}, 1'b1);         // Address in bits 17..16
  endtask

  // Four random array words, kept in array_img
  task automatic write_array();
    for (int a = 0; a < 4; a++) begin
      array_img[a] = 16'($urandom());
      issue_op(OP_W_CFG_ARRAY, {6'd0, 2'(a), array_img[a]}, 1'b1);
    end
  endtask

  // Cycle number of the next rising edge of bxclk (use_bx) or bxclk_ana
  task automatic wait_rise(input logic use_bx, output int at_cycle);
    logic prev;
    logic cur;
    logic found;
    prev  = use_bx ? bxclk : bxclk_ana;
    found = 1'b0;
    while (!found) begin
      @(negedge fw_axi_clk);
      cur   = use_bx ? bxclk : bxclk_ana;
      found = !prev && cur;
      prev  = cur;
    end
    at_cycle = cycle;
  endtask

  // Execute, then poll the done bit and count the cycles with reset_not low
  // scan_in is recorded once per bxclk period, starting the cycle after LOAD
  task automatic run_test(input logic [23:0] exec_word, input int bx_period,
                          output int low_cycles, output logic [63:0] scan_bits);
    int since_load;                                        // Falling edges since reset_not rose
    int nbits;
    low_cycles    = 0;
    scan_bits     = '0;
    since_load    = -1;
    nbits         = 0;
    op_code       = OP_W_EXECUTE;
    sw_write24    = exec_word;
    dev_id_enable = 1'b1;
    op_strobe     = 1'b1;
    @(negedge fw_axi_clk);
    op_strobe = 1'b0;
    op_code   = OP_NONE;
    while (!read_status32[12]) begin                       // Done bit
      if (!reset_not) begin
        low_cycles++;
      end else if (low_cycles > 0) begin
        since_load++;
        if (since_load >= 1 && nbits < 64 && (since_load - 1) % bx_period == 0) begin
          scan_bits[nbits] = scan_in;                      // Bit n sits there for one period
          nbits++;
        end
      end
      @(negedge fw_axi_clk);
    end
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic after_reset();
    check_value("read_status32", read_status32, 0);
    check_value("read_data32", read_data32, 0);
    check_value("reset_not", reset_not, 1);
    check_value("scan_in", scan_in, 0);
    check_value("super_pixel_sel", super_pixel_sel, 0);
    issue_op(OP_W_CFG_STATIC, 24'h00_1A5A, 1'b0);          // Device not selected
    issue_op(OP_R_CFG_STATIC, 24'h0, 1'b0);
    check_value("read_status32", read_status32, 0);
    issue_op(OP_R_CFG_STATIC, 24'h0, 1'b1);
    check_value("read_data32", read_data32, 0);            // Static word never written
    check_value("read_status32", read_status32, 32'h0000_0004);
    issue_op(OP_W_STATUS_CLEAR, 24'h0, 1'b1);
    check_value("read_status32", read_status32, 0);
  endtask

  task automatic static_and_array();
    logic [23:0] static_val;
    static_val = 24'($urandom());
    issue_op(OP_W_CFG_STATIC, static_val, 1'b1);
    issue_op(OP_R_CFG_STATIC, 24'h0, 1'b1);
    check_value("read_data32", read_data32, {8'h00, static_val});
    write_array();
    for (int a = 0; a < 4; a++) begin
      read_op(OP_R_CFG_ARRAY, a);                          // Address 3 pairs word0 with word3
      check_value("read_data32", read_data32, {array_img[(a + 1) % 4], array_img[a]});
    end
    check_value("read_status32", read_status32, 32'h0000_0066);  // Bits 1, 2, 5, 6
    issue_op(OP_W_STATUS_CLEAR, 24'h0, 1'b1);
    check_value("read_status32", read_status32, 0);
  endtask

  task automatic bxclk_timing();
    int t0;
    int t1;
    int t2;
    issue_op(OP_W_CFG_STATIC, 24'h00_008A, 1'b1);          // Period 10, delay 2, sign 0
    repeat (12) @(negedge fw_axi_clk);                     // Let the old waveform die out
    wait_rise(1'b0, t0);
    wait_rise(1'b0, t1);
    check_value("bxclk_ana period", t1 - t0, 10);
    wait_rise(1'b1, t2);
    check_value("bxclk delay", t2 - t1, 2);
    issue_op(OP_W_CFG_STATIC, 24'h00_088A, 1'b1);          // Same, sign 1
    repeat (12) @(negedge fw_axi_clk);
    wait_rise(1'b0, t0);
    wait_rise(1'b1, t1);
    wait_rise(1'b0, t2);
    check_value("bxclk_ana period", t2 - t0, 10);
    check_value("bxclk advance", t2 - t1, 2);
  endtask

  task automatic loopback_run();
    int          low_cycles;
    logic [63:0] scan_bits;
    issue_op(OP_W_CFG_STATIC, 24'h00_108A, 1'b1);          // Period 10, delay 2, super pixel
    write_array();
    check_value("super_pixel_sel", super_pixel_sel, 0);    // Still idle
    issue_op(OP_W_STATUS_CLEAR, 24'h0, 1'b1);
    run_test(24'h01_01C4, 10, low_cycles, scan_bits);      // Loopback, delay 4, sample 7
    check_value("reset_not low cycles", low_cycles, 10);   // One bxclk period
    check_value("scan_in bits", scan_bits,
                {array_img[3], array_img[2], array_img[1], array_img[0]});
    check_value("read_status32", read_status32, 32'h0000_1800);
    check_value("reset_not", reset_not, 1);
    check_value("super_pixel_sel", super_pixel_sel, 1);
    // First bit out lands in bit 0, so the capture equals the array image
    read_op(OP_R_DATA_ARRAY, 0);
    check_value("read_data32", read_data32, {array_img[1], array_img[0]});
    read_op(OP_R_DATA_ARRAY, 1);
    check_value("read_data32", read_data32, {array_img[3], array_img[2]});
  endtask

  task automatic capture_with_error();
    int          low_cycles;
    logic [63:0] scan_bits;
    scan_out = 1'b1;
    issue_op(OP_W_STATUS_CLEAR, 24'h0, 1'b1);
    run_test(24'h00_0181, 10, low_cycles, scan_bits);      // Delay 1 is below the minimum
    check_value("reset_not low cycles", low_cycles, 10);
    check_value("scan_in bits", scan_bits,                 // Array left as loaded before
                {array_img[3], array_img[2], array_img[1], array_img[0]});
    check_value("read_status32", read_status32, 32'h8000_1800);
    read_op(OP_R_DATA_ARRAY, 0);
    check_value("read_data32", read_data32, 32'hFFFF_FFFF);
    read_op(OP_R_DATA_ARRAY, 1);
    check_value("read_data32", read_data32, 32'hFFFF_FFFF);
    read_op(OP_R_DATA_ARRAY, 2);                           // Past the capture words
    check_value("read_data32", read_data32, 0);
    check_value("read_status32", read_status32, 32'h8000_1A00);
    scan_out = 1'b0;
  endtask

//--- verif/tb_fw_ip2.sv
/* Testbench for fw_ip2_top, inputs change on the falling edge and outputs are read there
   Clock period 100 units; bxclk timing is measured in fw_axi_clk cycles */
module tb_fw_ip2 import fw_ip2_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 20000;                   // Five tests, each under 1000 cycles

  logic        fw_axi_clk;
  logic        op_code_w_reset;
  logic        dev_id_enable;
  logic        op_strobe;
  op_code_t    op_code;
  logic [23:0] sw_write24;
  logic        scan_out;                                   // Driven in place of the ASIC
  logic [31:0] read_data32;
  logic [31:0] read_status32;
  logic        super_pixel_sel;
  logic        reset_not;
  logic        scan_in;
  logic        bxclk;
  logic        bxclk_ana;
  int          cycle = 0;                                  // Rising edges since time 0
  logic [15:0] array_img [4];                              // Last words written to the array

  fw_ip2_top fw_ip2_top_inst (.*);

  // --------------------------------------------------------------------------
  // Clock and cycle limit
  // --------------------------------------------------------------------------
  initial fw_axi_clk = 1'b0;
  always #50 fw_axi_clk = ~fw_axi_clk;

  always @(posedge fw_axi_clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  `include "tb_fw_ip2_tasks.svh"

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    void'($urandom(94789));                                // One seed for the whole run
    op_code_w_reset = 1'b1;
    dev_id_enable   = 1'b0;
    op_strobe       = 1'b0;
    op_code         = OP_NONE;
    sw_write24      = '0;
    scan_out        = 1'b0;
    repeat (2) @(negedge fw_axi_clk);                      // Reset held for two cycles
    op_code_w_reset = 1'b0;
    @(negedge fw_axi_clk);

    after_reset();
    static_and_array();
    bxclk_timing();
    loopback_run();
    capture_with_error();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
